//--- Bender.yml
package:
  name: conv3x3

sources:
  - hw/conv3x3_pkg.sv
  - hw/tap_if.sv
  - hw/kernel_loader.sv
  - hw/window_gen.sv
  - hw/mac_3x3.sv
  - hw/conv3x3_top.sv
  - target: test
    files:
      - dv/conv3x3_checker.sv
      - dv/conv3x3_tb.sv

//--- conv3x3_top.f
hw/conv3x3_pkg.sv
hw/tap_if.sv
hw/kernel_loader.sv
hw/window_gen.sv
hw/mac_3x3.sv
hw/conv3x3_top.sv
dv/conv3x3_checker.sv
dv/conv3x3_tb.sv

//--- dv/conv3x3_checker.sv
module conv3x3_checker import conv3x3_pkg::*; #(
	parameter int IMG_WIDTH    = 8,
	parameter int IMG_HEIGHT   = 8,
	parameter int KERNEL_DEPTH = 4
) (
	input logic  clk,
	input logic  reset,
	input data_t weight_in,
	input logic  weight_valid,
	input logic  load_weights,
	input data_t pixel_in,
	input logic  pixel_valid,
	input logic  kernel_ready,
	input acc_t  result,
	input logic  result_valid
);

	timeunit 1ns;
	timeprecision 1ns;

	int     value_errors = 0;
	int     protocol_errors = 0;
	int     results_seen = 0;
	int     pending = 0;
	int     wcnt;
	int     col;
	int     row;
	longint cycle;
	logic   ready_model;
	acc_t   sum;
	acc_t   exp_val;
	longint due;
	data_t  wbuf [KERNEL_TAPS];
	data_t  active [KERNEL_TAPS];
	data_t  frame [IMG_HEIGHT][IMG_WIDTH];
	// Queued kernels, nine weights each, oldest first
	data_t  kq [$];
	acc_t   exp_q [$];
	longint due_q [$];

	////////////////////
	// Compare, then advance the model

	always @(posedge clk) begin
		if (reset) begin
			wcnt = 0;
			col = 0;
			row = 0;
			cycle = 0;
			ready_model = 1'b0;
			kq.delete();
			exp_q.delete();
			due_q.delete();
		end else begin
			cycle++;
			if (kernel_ready !== ready_model) begin
				protocol_errors++;
				$display("Error kernel_ready: expected %0b, actual %0b", ready_model, kernel_ready);
			end
			if (result_valid !== 1'b0) begin
				// Every result pulse counts, expected or not
				results_seen++;
				if (exp_q.size() == 0) begin
					protocol_errors++;
					$display("Result appeared at cycle %0d with no window pending", cycle);
				end else begin
					exp_val = exp_q.pop_front();
					due = due_q.pop_front();
					if (due != cycle) begin
						protocol_errors++;
						$display("Error result_timing: expected cycle %0d, actual cycle %0d",
							due, cycle);
					end
					if (result !== exp_val) begin
						value_errors++;
						$display("Error convolution: expected %0d, actual %0d", exp_val, result);
					end
				end
			end
			// Load ignored while the queue is empty
			if (load_weights && kq.size() > 0) begin
				for (int i = 0; i < KERNEL_TAPS; i++) begin
					active[i] = kq.pop_front();
				end
				ready_model = 1'b1;
			end
			if (weight_valid) begin
				wbuf[wcnt] = weight_in;
				wcnt++;
				if (wcnt == KERNEL_TAPS) begin
					wcnt = 0;
					if (kq.size() < KERNEL_DEPTH * KERNEL_TAPS) begin
						for (int i = 0; i < KERNEL_TAPS; i++) begin
							kq.push_back(wbuf[i]);
						end
					end
				end
			end
			if (pixel_valid) begin
				frame[row][col] = pixel_in;
				// Window covers rows r-2..r and columns c-2..c
				if (col >= 2 && row >= 2) begin
					sum = '0;
					for (int i = 0; i < KERNEL_TAPS; i++) begin
						sum += acc_t'(frame[row - 2 + i / 3][col - 2 + i % 3])
							* acc_t'(active[i]);
					end
					exp_q.push_back(sum);
					due_q.push_back(cycle + 3);
				end
				if (col == IMG_WIDTH - 1) begin
					col = 0;
					row = (row == IMG_HEIGHT - 1) ? 0 : row + 1;
				end else begin
					col++;
				end
			end
			pending = exp_q.size();
		end
	end

endmodule

//--- dv/conv3x3_tb.sv
module conv3x3_tb import conv3x3_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int IMG_WIDTH    = 8;
	localparam int IMG_HEIGHT   = 8;
	localparam int KERNEL_DEPTH = 4;
	localparam int FRAMES       = 3;
	localparam int MAX_GAP      = 3;
	localparam int PERIOD       = 40;
	localparam int WINDOWS      = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2);
	// Pipeline latency plus some slack
	localparam int DRAIN_LIMIT  = 8;
	// Worst case with every strobe followed by the longest gap, plus margin
	localparam longint TIMEOUT =
		(FRAMES * (IMG_WIDTH * IMG_HEIGHT + KERNEL_TAPS) * (MAX_GAP + 1) + 200) * PERIOD;

	logic   clk = 1'b0;
	logic   reset;
	data_t  weight_in;
	logic   weight_valid;
	logic   load_weights;
	data_t  pixel_in;
	logic   pixel_valid;
	logic   kernel_ready;
	acc_t   result;
	logic   result_valid;
	integer seed = 32'h3d12;
	int     frame_errors = 0;

	always #(PERIOD / 2) clk = ~clk;

	conv3x3_top #(
		.IMG_WIDTH    (IMG_WIDTH),
		.IMG_HEIGHT   (IMG_HEIGHT),
		.KERNEL_DEPTH (KERNEL_DEPTH)
	) dut (.*);

	conv3x3_checker #(
		.IMG_WIDTH    (IMG_WIDTH),
		.IMG_HEIGHT   (IMG_HEIGHT),
		.KERNEL_DEPTH (KERNEL_DEPTH)
	) chk (.*);

	// Called and returning on a falling edge
	task automatic idle_gap();
		int n;
		n = $unsigned($random(seed)) % (MAX_GAP + 1);
		repeat (n) @(negedge clk);
	endtask

	task automatic send_kernel();
		for (int t = 0; t < KERNEL_TAPS; t++) begin
			weight_in = data_t'($random(seed));
			weight_valid = 1'b1;
			@(negedge clk);
			weight_valid = 1'b0;
			idle_gap();
		end
	endtask

	task automatic send_frame();
		for (int p = 0; p < IMG_WIDTH * IMG_HEIGHT; p++) begin
			pixel_in = data_t'($random(seed));
			pixel_valid = 1'b1;
			@(negedge clk);
			pixel_valid = 1'b0;
			idle_gap();
		end
	endtask

	// Returns once no result is outstanding, or after DRAIN_LIMIT cycles
	task automatic wait_drain();
		int waited;
		waited = 0;
		while (chk.pending != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
	endtask

	////////////////////
	// Main sequence

	initial begin
		reset = 1'b1;
		weight_in = '0;
		weight_valid = 1'b0;
		load_weights = 1'b0;
		pixel_in = '0;
		pixel_valid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);
		for (int k = 0; k < FRAMES; k++) begin
			send_kernel();
		end
		repeat (2) @(negedge clk);
		for (int f = 0; f < FRAMES; f++) begin
			load_weights = 1'b1;
			@(negedge clk);
			load_weights = 0;
			idle_gap();
			send_frame();
			wait_drain();
			// Catch any stray result after the drain
			repeat (4) @(negedge clk);
			if (chk.results_seen != (f + 1) * WINDOWS) begin
				frame_errors++;
				$display("Error frame_count: expected %0d, actual %0d",
					(f + 1) * WINDOWS, chk.results_seen);
			end
		end
		$display("Errors: value %0d, protocol %0d, frame count %0d",
			chk.value_errors, chk.protocol_errors, frame_errors);
		if (chk.value_errors + chk.protocol_errors + frame_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog expired after %0d ns before the tests finished", TIMEOUT);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- hw/conv3x3_pkg.sv
package conv3x3_pkg;

	////////////////////
	// Data widths

	// Pixels and weights share one signed format
	typedef logic signed [15:0] data_t;

	// Nine full-scale 16x16 products summed without overflow
	typedef logic signed [35:0] acc_t;

	////////////////////
	// Kernel geometry

	localparam int KERNEL_TAPS = 9;

	// Counts weights within one kernel
	typedef logic [3:0] tap_idx_t;

	////////////////////
	// Kernel loader FSM

	typedef enum logic {
		COLLECT,
		WRITE
	} loader_state_e;

endpackage

//--- hw/conv3x3_top.sv
module conv3x3_top import conv3x3_pkg::*; #(
	parameter int IMG_WIDTH    = 8,
	parameter int IMG_HEIGHT   = 8,
	parameter int KERNEL_DEPTH = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  data_t weight_in,
	input  logic  weight_valid,
	input  logic  load_weights,
	input  data_t pixel_in,
	input  logic  pixel_valid,
	output logic  kernel_ready,
	output acc_t  result,
	output logic  result_valid
);

	// Active kernel, level valid
	tap_if weight_taps ();

	// Pixel window, one strobe per window
	tap_if window_taps ();

	kernel_loader #(
		.KERNEL_DEPTH (KERNEL_DEPTH)
	) u_kernel_loader (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.load_weights (load_weights),
		.kernel_ready (kernel_ready),
		.taps         (weight_taps.source)
	);

	window_gen #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) u_window_gen (
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.pixel_in    (pixel_in),
		.window      (window_taps.source)
	);

	mac_3x3 u_mac_3x3 (
		.clk          (clk),
		.reset        (reset),
		.weights      (weight_taps.sink),
		.window       (window_taps.sink),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

//--- hw/kernel_loader.sv
module kernel_loader import conv3x3_pkg::*; #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  weight_valid,
	input  data_t weight_in,
	input  logic  load_weights,
	output logic  kernel_ready,
	tap_if.source taps
);

	localparam int PTR_W = (KERNEL_DEPTH > 1) ? $clog2(KERNEL_DEPTH) : 1;
	localparam int FILL_W = $clog2(KERNEL_DEPTH + 1);

	data_t            chain [KERNEL_TAPS];
	data_t            kernel_mem [KERNEL_DEPTH][KERNEL_TAPS];
	data_t            active [KERNEL_TAPS];
	tap_idx_t         weight_cnt;
	loader_state_e    state;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [FILL_W-1:0] fill;
	logic             full;
	logic             empty;
	logic             wr_en;
	logic             rd_en;
	logic             last_weight;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(KERNEL_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	////////////////////
	// Weight shift chain

	// First weight of a kernel ends up in chain[0]
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			for (int i = 0; i < KERNEL_TAPS - 1; i++) begin
				chain[i] <= chain[i + 1];
			end
			chain[KERNEL_TAPS - 1] <= weight_in;
		end
	end

	assign last_weight = weight_valid && (weight_cnt == tap_idx_t'(KERNEL_TAPS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			weight_cnt <= '0;
			state      <= COLLECT;
		end else begin
			if (weight_valid) begin
				weight_cnt <= last_weight ? '0 : weight_cnt + 1'b1;
			end
			case (state)
				COLLECT: state <= last_weight ? WRITE : COLLECT;
				WRITE:   state <= COLLECT;
				default: state <= COLLECT;
			endcase
		end
	end

	////////////////////
	// Kernel queue

	assign full  = (fill == FILL_W'(KERNEL_DEPTH));
	assign empty = (fill == '0);
	// Kernel dropped when full, load ignored when empty
	assign wr_en = (state == WRITE) && !full;
	assign rd_en = load_weights && !empty;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			kernel_mem[wr_ptr] <= chain;
		end
		if (rd_en) begin
			active <= kernel_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			fill         <= '0;
			kernel_ready <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr       <= next_ptr(rd_ptr);
				kernel_ready <= 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	assign taps.taps  = active;
	assign taps.valid = kernel_ready;

	a_load_not_empty: assert property (@(posedge clk) disable iff (reset)
		load_weights |-> !empty)
		else $error("kernel_loader: load_weights with empty kernel queue");

	a_write_not_full: assert property (@(posedge clk) disable iff (reset)
		(state == WRITE) |-> !full)
		else $error("kernel_loader: kernel dropped, queue full");

endmodule

//--- hw/mac_3x3.sv
module mac_3x3 import conv3x3_pkg::*; (
	input  logic clk,
	input  logic reset,
	tap_if.sink  weights,
	tap_if.sink  window,
	output acc_t result,
	output logic result_valid
);

	localparam int PROD_W = 2 * $bits(data_t);

	typedef logic signed [PROD_W-1:0] prod_t;

	prod_t products [KERNEL_TAPS];
	logic  prod_valid;
	acc_t  tap_sum;

	////////////////////
	// Stage one

	// Active kernel sampled in the same cycle as the window strobe
	always_ff @(posedge clk) begin
		for (int i = 0; i < KERNEL_TAPS; i++) begin
			products[i] <= weights.taps[i] * window.taps[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= window.valid;
		end
	end

	////////////////////
	// Stage two

	// Adder tree over the sign-extended products
	always_comb begin
		tap_sum = '0;
		for (int i = 0; i < KERNEL_TAPS; i++) begin
			tap_sum += acc_t'(products[i]);
		end
	end

	always_ff @(posedge clk) begin
		result <= tap_sum;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= prod_valid;
		end
	end

	a_kernel_loaded: assert property (@(posedge clk) disable iff (reset)
		window.valid |-> weights.valid)
		else $error("mac_3x3: window arrived before any kernel was loaded");

endmodule

//--- hw/tap_if.sv
interface tap_if import conv3x3_pkg::*; ();

	// Tap 0 is top-left, tap 8 bottom-right, raster order
	data_t taps [KERNEL_TAPS];
	logic  valid;

	modport source (
		output taps,
		output valid
	);

	modport sink (
		input taps,
		input valid
	);

endinterface

//--- hw/window_gen.sv
module window_gen import conv3x3_pkg::*; #(
	parameter int IMG_WIDTH  = 8,
	parameter int IMG_HEIGHT = 8
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  pixel_valid,
	input  data_t pixel_in,
	tap_if.source window
);

	localparam int COL_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
	localparam int ROW_W = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;

	// Row r-1 and row r-2, indexed by column
	data_t            line_prev [IMG_WIDTH];
	data_t            line_old [IMG_WIDTH];
	data_t            win [3][3];
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic             col_last;
	logic             row_last;
	logic             win_done;
	logic             win_valid;

	assign col_last = (col == COL_W'(IMG_WIDTH - 1));
	assign row_last = (row == ROW_W'(IMG_HEIGHT - 1));
	assign win_done = pixel_valid && (col >= 2) && (row >= 2);

	////////////////////
	// Position tracking

	// Both counters wrap after the last pixel of a frame
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (pixel_valid) begin
			if (col_last) begin
				col <= '0;
				row <= row_last ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	////////////////////
	// Line buffers

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			line_old[col]  <= line_prev[col];
			line_prev[col] <= pixel_in;
		end
	end

	////////////////////
	// Window registers

	// Shift left, new column enters on the right
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			for (int r = 0; r < 3; r++) begin
				win[r][0] <= win[r][1];
				win[r][1] <= win[r][2];
			end
			win[0][2] <= line_old[col];
			win[1][2] <= line_prev[col];
			win[2][2] <= pixel_in;
		end
	end

	// One strobe per complete window, a cycle after its last pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= win_done;
		end
	end

	for (genvar r = 0; r < 3; r++) begin : g_row
		for (genvar c = 0; c < 3; c++) begin : g_col
			assign window.taps[r * 3 + c] = win[r][c];
		end
	end

	assign window.valid = win_valid;

	a_pos_in_frame: assert property (@(posedge clk) disable iff (reset)
		(col < IMG_WIDTH) && (row < IMG_HEIGHT))
		else $error("window_gen: position counter outside frame");

endmodule
